// ==== design/frontend_params.svh ====
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

// program counter after reset
`define FE_RESET_PC     32'h1eceb000

// instruction and address width
`define FE_XLEN         32

// burst memory beat geometry
`define FE_BEAT_W       64
`define FE_BEATS        4

// one line is FE_BEATS beats
`define FE_LINE_W       256

// byte offset bits inside a line
`define FE_OFFSET_W     5

// entries in the fetch queue
`define FE_QUEUE_DEPTH  8

`endif

// ==== design/frontend_pkg.sv ====
`include "frontend_params.svh"

package frontend_pkg;

    // read request for one line, held until the response strobe
    typedef struct packed {
        logic                   valid;
        logic [`FE_XLEN-1:0]    addr;   // line aligned
    } line_req_t;

    // line response, valid is a one-cycle strobe
    typedef struct packed {
        logic                   valid;
        logic [`FE_LINE_W-1:0]  data;
    } line_rsp_t;

    // one fetched instruction with its pc
    typedef struct packed {
        logic [`FE_XLEN-1:0]    pc;
        logic [`FE_XLEN-1:0]    inst;
    } fetch_entry_t;

    // taken branch from the back end
    typedef struct packed {
        logic                   taken;
        logic [`FE_XLEN-1:0]    target;
    } redirect_t;

endpackage : frontend_pkg

// ==== design/burst_adapter.sv ====
`timescale 1ns/1ps
`include "frontend_params.svh"

module burst_adapter
import frontend_pkg::*;
(
    input   logic                   clk,
    input   logic                   rst,

    input   logic [`FE_XLEN-1:0]    bmem_raddr_i,
    input   logic [`FE_BEAT_W-1:0]  bmem_rdata_i,
    input   logic                   bmem_rvalid_i,

    output  line_rsp_t              line_o
);

    localparam int CNT_W = $clog2(`FE_BEATS);

    logic [CNT_W-1:0]                       beat_cnt;
    logic                                   line_valid_q;
    logic [`FE_LINE_W-1:0]                  line_buf;
    logic [`FE_XLEN-`FE_OFFSET_W-1:0]       first_line_q;
    logic                                   last_beat;

    assign last_beat = bmem_rvalid_i && (beat_cnt == CNT_W'(`FE_BEATS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt     <= '0;
            line_valid_q <= 1'b0;
        end else begin
            line_valid_q <= last_beat;  // strobe one cycle after beat 4
            if (bmem_rvalid_i) begin
                beat_cnt <= beat_cnt + 1'b1;   // wraps after the last beat
            end
        end
    end

    // beat k lands in bits [64k +: 64]
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_buf[beat_cnt*`FE_BEAT_W +: `FE_BEAT_W] <= bmem_rdata_i;
        end
        if (bmem_rvalid_i && beat_cnt == '0) begin
            first_line_q <= bmem_raddr_i[`FE_XLEN-1:`FE_OFFSET_W];
        end
    end

    assign line_o.valid = line_valid_q;
    assign line_o.data  = line_buf;

    strobe_one_cycle: assert property (@(posedge clk) disable iff (rst)
        line_valid_q |=> !line_valid_q);

    // all beats of a burst come from the same line
    beats_same_line: assert property (@(posedge clk) disable iff (rst)
        (bmem_rvalid_i && beat_cnt != '0) |->
            (bmem_raddr_i[`FE_XLEN-1:`FE_OFFSET_W] == first_line_q));

endmodule : burst_adapter

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ps
`include "frontend_params.svh"

module mem_arbiter
import frontend_pkg::*;
(
    input   logic                   clk,
    input   logic                   rst,

    input   line_req_t              ireq_i,
    input   line_req_t              dreq_i,
    output  line_rsp_t              irsp_o,
    output  line_rsp_t              drsp_o,

    input   line_rsp_t              line_i,

    input   logic                   bmem_ready_i,
    output  logic [`FE_XLEN-1:0]    bmem_addr_o,
    output  logic                   bmem_read_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT
    } arb_state_e;

    arb_state_e             state_q, state_d;
    logic                   gnt_data_q, gnt_data_d;
    logic [`FE_XLEN-1:0]    addr_q, addr_d;

    always_comb begin
        state_d     = state_q;
        gnt_data_d  = gnt_data_q;
        addr_d      = addr_q;
        bmem_addr_o = addr_q;
        bmem_read_o = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (dreq_i.valid || ireq_i.valid) begin
                    gnt_data_d  = dreq_i.valid;     // data side wins
                    addr_d      = dreq_i.valid ? dreq_i.addr : ireq_i.addr;
                    bmem_addr_o = addr_d;
                    bmem_read_o = bmem_ready_i;
                    state_d     = bmem_ready_i ? ST_WAIT : ST_ISSUE;
                end
            end
            ST_ISSUE: begin
                bmem_read_o = bmem_ready_i;
                if (bmem_ready_i) begin
                    state_d = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (line_i.valid) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ST_IDLE;
            gnt_data_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            gnt_data_q <= gnt_data_d;
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= addr_d;
    end

    // line goes back to the granted side only
    assign irsp_o.valid = line_i.valid && (state_q == ST_WAIT) && !gnt_data_q;
    assign irsp_o.data  = line_i.data;
    assign drsp_o.valid = line_i.valid && (state_q == ST_WAIT) && gnt_data_q;
    assign drsp_o.data  = line_i.data;

    one_burst_outstanding: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |=> (!bmem_read_o throughout line_i.valid [->1]));

endmodule : mem_arbiter

// ==== design/fetch_ctrl.sv ====
`timescale 1ns/1ps
`include "frontend_params.svh"

module fetch_ctrl
import frontend_pkg::*;
(
    input   logic           clk,
    input   logic           rst,

    input   redirect_t      redirect_i,
    input   logic           full_i,

    output  line_req_t      ireq_o,
    input   line_rsp_t      irsp_i,

    output  logic           push_o,
    output  fetch_entry_t   entry_o
);

    localparam int TAG_W  = `FE_XLEN - `FE_OFFSET_W;
    localparam int WSEL_W = `FE_OFFSET_W - 2;

    logic [`FE_XLEN-1:0]    pc_q;
    logic                   buf_valid_q;
    logic [TAG_W-1:0]       buf_tag_q;
    logic [`FE_LINE_W-1:0]  buf_data_q;
    logic                   req_valid_q;
    logic [`FE_XLEN-1:0]    req_addr_q;
    logic                   discard_q;
    logic                   line_hit;
    logic                   take_redirect;
    logic [WSEL_W-1:0]      word_sel;

    assign take_redirect = redirect_i.taken;
    assign line_hit      = buf_valid_q && (buf_tag_q == pc_q[`FE_XLEN-1:`FE_OFFSET_W]);
    assign word_sel      = pc_q[`FE_OFFSET_W-1:2];

    // nothing pushed in the flush cycle
    assign push_o        = line_hit && !full_i && !take_redirect;
    assign entry_o.pc    = pc_q;
    assign entry_o.inst  = buf_data_q[word_sel*`FE_XLEN +: `FE_XLEN];

    assign ireq_o.valid  = req_valid_q;
    assign ireq_o.addr   = req_addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q        <= `FE_RESET_PC;
            buf_valid_q <= 1'b0;
            req_valid_q <= 1'b0;
            discard_q   <= 1'b0;
        end else begin
            if (take_redirect) begin
                pc_q <= redirect_i.target;
            end else if (push_o) begin
                pc_q <= pc_q + 32'd4;
            end

            if (irsp_i.valid) begin
                req_valid_q <= 1'b0;
            end else if (!req_valid_q && !line_hit && !take_redirect) begin
                req_valid_q <= 1'b1;    // line miss
            end

            if (take_redirect) begin
                buf_valid_q <= 1'b0;
                discard_q   <= req_valid_q && !irsp_i.valid;  // old line still in flight
            end else if (irsp_i.valid) begin
                buf_valid_q <= !discard_q;
                discard_q   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!req_valid_q) begin
            req_addr_q <= {pc_q[`FE_XLEN-1:`FE_OFFSET_W], {`FE_OFFSET_W{1'b0}}};
        end
        if (irsp_i.valid) begin
            buf_tag_q  <= req_addr_q[`FE_XLEN-1:`FE_OFFSET_W];
            buf_data_q <= irsp_i.data;
        end
    end

endmodule : fetch_ctrl

// ==== design/fetch_queue.sv ====
`timescale 1ns/1ps
`include "frontend_params.svh"

module fetch_queue
import frontend_pkg::*;
(
    input   logic           clk,
    input   logic           rst,

    input   logic           push_i,
    input   fetch_entry_t   entry_i,
    input   logic           deq_i,
    input   logic           flush_i,

    output  fetch_entry_t   head_o,
    output  logic           valid_o,
    output  logic           full_o
);

    localparam int PTR_W = $clog2(`FE_QUEUE_DEPTH);

    fetch_entry_t       mem [`FE_QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr, rd_ptr;
    logic [PTR_W:0]     count;
    logic               do_push, do_pop;

    assign valid_o = (count != '0);
    assign full_o  = (count == (PTR_W+1)'(`FE_QUEUE_DEPTH));
    assign head_o  = mem[rd_ptr];

    assign do_push = push_i && !full_o;
    assign do_pop  = deq_i && valid_o;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= entry_i;
        end
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        push_i |-> !full_o);

    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
        deq_i |-> valid_o);

endmodule : fetch_queue

// ==== design/fetch_frontend.sv ====
`timescale 1ns/1ps
`include "frontend_params.svh"

module fetch_frontend
import frontend_pkg::*;
(
    input   logic                   clk,
    input   logic                   rst,

    input   redirect_t              redirect_i,
    input   logic                   deq_i,
    output  fetch_entry_t           inst_o,
    output  logic                   inst_valid_o,

    input   line_req_t              dreq_i,
    output  line_rsp_t              drsp_o,

    output  logic [`FE_XLEN-1:0]    bmem_addr_o,
    output  logic                   bmem_read_o,
    input   logic                   bmem_ready_i,
    input   logic [`FE_XLEN-1:0]    bmem_raddr_i,
    input   logic [`FE_BEAT_W-1:0]  bmem_rdata_i,
    input   logic                   bmem_rvalid_i
);

    line_req_t      ireq;
    line_rsp_t      irsp;
    line_rsp_t      line;
    logic           push;
    fetch_entry_t   entry;
    logic           queue_full;

    fetch_ctrl fetch_ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .redirect_i (redirect_i),
        .full_i     (queue_full),
        .ireq_o     (ireq),
        .irsp_i     (irsp),
        .push_o     (push),
        .entry_o    (entry)
    );

    fetch_queue fetch_queue_i (
        .clk        (clk),
        .rst        (rst),
        .push_i     (push),
        .entry_i    (entry),
        .deq_i      (deq_i),
        .flush_i    (redirect_i.taken),  // empties in the redirect cycle
        .head_o     (inst_o),
        .valid_o    (inst_valid_o),
        .full_o     (queue_full)
    );

    mem_arbiter mem_arbiter_i (
        .clk          (clk),
        .rst          (rst),
        .ireq_i       (ireq),
        .dreq_i       (dreq_i),
        .irsp_o       (irsp),
        .drsp_o       (drsp_o),
        .line_i       (line),
        .bmem_ready_i (bmem_ready_i),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o)
    );

    burst_adapter burst_adapter_i (
        .clk           (clk),
        .rst           (rst),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .line_o        (line)
    );

endmodule : fetch_frontend

// ==== dv/bmem_model.sv ====
`timescale 1ns/1ps
`include "frontend_params.svh"

module bmem_model #(
    parameter logic [31:0]  PATTERN     = 32'h0,
    parameter logic [31:0]  SEED        = 32'd17,
    parameter int           DRIVE_DELAY = 1
) (
    input   logic                   clk,
    input   logic                   rst,
    input   logic [`FE_XLEN-1:0]    bmem_addr_i,
    input   logic                   bmem_read_i,
    output  logic                   bmem_ready_o,
    output  logic [`FE_XLEN-1:0]    bmem_raddr_o,
    output  logic [`FE_BEAT_W-1:0]  bmem_rdata_o,
    output  logic                   bmem_rvalid_o
);

    logic [31:0]            rng;
    logic [`FE_XLEN-1:0]    burst_addr;
    logic [`FE_XLEN-1:0]    beat_addr;
    logic                   busy;
    int                     beat;
    int                     delay;
    int                     low_left;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        bmem_ready_o  = 1'b0;
        bmem_raddr_o  = '0;
        bmem_rdata_o  = '0;
        bmem_rvalid_o = 1'b0;
        rng           = SEED;
        busy          = 1'b0;
        low_left      = 0;
        forever begin
            @(posedge clk);
            if (rst) begin
                busy = 1'b0;
            end else if (bmem_read_i) begin
                burst_addr = bmem_addr_i;
                busy       = 1'b1;
                beat       = 0;
                rng        = xorshift32(rng);
                delay      = rng % 6;   // first beat 1 to 6 cycles later
            end
            #DRIVE_DELAY;
            rng = xorshift32(rng);
            if (low_left > 0) begin
                low_left--;
            end else if (rng[2:0] == 3'd0) begin
                low_left = 1 + rng[4:3];    // busy for 1 to 4 cycles
            end
            bmem_ready_o  = (low_left == 0);
            bmem_rvalid_o = 1'b0;
            if (busy && delay > 0) begin
                delay--;
            end else if (busy) begin
                beat_addr     = burst_addr + 32'(8 * beat);
                bmem_raddr_o  = beat_addr;
                bmem_rdata_o  = {(beat_addr + 32'd4) ^ PATTERN, beat_addr ^ PATTERN};
                bmem_rvalid_o = 1'b1;
                beat++;
                busy  = (beat < `FE_BEATS);
                delay = rng[9:5] % 3;   // gap before the next beat
            end
        end
    end

endmodule : bmem_model

// ==== dv/tb_fetch_frontend.sv ====
`timescale 1ns/1ps
`include "frontend_params.svh"

module tb_fetch_frontend
import frontend_pkg::*;
();

    localparam int          CLK_PERIOD    = 100;
    localparam int          DRIVE_DELAY   = 1;
    localparam int          RESET_CYCLES  = 5;
    localparam logic [31:0] MEM_PATTERN   = 32'h5a3c96e1;
    localparam logic [31:0] RNG_SEED      = 32'd17;
    localparam int          SEQ_POPS      = 40;
    localparam int          BP_POPS       = 12;
    localparam int          STALL_CYCLES  = 24 * `FE_QUEUE_DEPTH;
    localparam int          N_REDIRECTS   = 6;
    localparam int          REDIRECT_POPS = 12;
    localparam int          DATA_POPS     = 48;
    localparam int          N_DREQ        = 6;
    localparam int          MISS_CYCLES   = 64;   // fetch burst queued behind a data burst
    localparam int          TOTAL_STEPS   = 1 + SEQ_POPS + 2 * BP_POPS + DATA_POPS + N_DREQ
                                          + N_REDIRECTS * (REDIRECT_POPS + 6);
    localparam int          WATCHDOG_CYCLES = RESET_CYCLES + 2 * STALL_CYCLES + N_DREQ * 60
                                            + TOTAL_STEPS * MISS_CYCLES;

    logic                   clk;
    logic                   rst;
    redirect_t              redirect;
    logic                   deq;
    fetch_entry_t           head;
    logic                   head_valid;
    line_req_t              dreq;
    line_rsp_t              drsp;
    logic [`FE_XLEN-1:0]    bmem_addr;
    logic                   bmem_read;
    logic                   bmem_ready;
    logic [`FE_XLEN-1:0]    bmem_raddr;
    logic [`FE_BEAT_W-1:0]  bmem_rdata;
    logic                   bmem_rvalid;

    logic [31:0]            exp_pc;
    logic [31:0]            rng_state   = RNG_SEED;
    int                     check_count = 0;
    int                     error_count = 0;
    int                     test_checks = 0;
    int                     test_errors = 0;
    int                     req_count   = 0;
    int                     resp_count  = 0;

    fetch_frontend DUT (
        .clk          (clk),
        .rst          (rst),
        .redirect_i   (redirect),
        .deq_i        (deq),
        .inst_o       (head),
        .inst_valid_o (head_valid),
        .dreq_i       (dreq),
        .drsp_o       (drsp),
        .bmem_addr_o  (bmem_addr),
        .bmem_read_o  (bmem_read),
        .bmem_ready_i (bmem_ready),
        .bmem_raddr_i (bmem_raddr),
        .bmem_rdata_i (bmem_rdata),
        .bmem_rvalid_i(bmem_rvalid)
    );

    bmem_model #(.PATTERN(MEM_PATTERN), .SEED(RNG_SEED), .DRIVE_DELAY(DRIVE_DELAY)) mem_model (
        .clk          (clk),
        .rst          (rst),
        .bmem_addr_i  (bmem_addr),
        .bmem_read_i  (bmem_read),
        .bmem_ready_o (bmem_ready),
        .bmem_raddr_o (bmem_raddr),
        .bmem_rdata_o (bmem_rdata),
        .bmem_rvalid_o(bmem_rvalid)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // memory rule: word at byte address a is a xor pattern
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return addr ^ MEM_PATTERN;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        $display("[%0t ns] %s: %0d checks, %0d errors", $time, name,
                 check_count - test_checks, error_count - test_errors);
        test_checks = check_count;
        test_errors = error_count;
    endtask

    // pops n entries, only while the head is valid
    task automatic pop_entries(input int n);
        int popped;
        popped = 0;
        while (popped < n) begin
            deq = head_valid;
            @(posedge clk);
            if (deq) begin
                popped++;
            end
            #DRIVE_DELAY;
        end
        deq = 1'b0;
    endtask

    task automatic issue_data_requests();
        logic [31:0] r;
        int          k;
        int          gap;
        for (k = 0; k < N_DREQ; k++) begin
            r   = next_random();
            gap = (k % 2 == 0) ? int'(r % 16) : 40;
            // odd requests try to land while a fetch miss is pending
            while (gap > 0 && !(k % 2 == 1 && DUT.ireq.valid)) begin
                @(posedge clk);
                #DRIVE_DELAY;
                gap--;
            end
            dreq.valid = 1'b1;
            dreq.addr  = {r[31:5], 5'b0};
            req_count++;
            @(posedge clk);
            while (!drsp.valid) begin
                @(posedge clk);
            end
            #DRIVE_DELAY;
            dreq = '0;
        end
    endtask

    always @(posedge clk) begin : compare_outputs
        int w;
        if (rst) begin
            exp_pc = `FE_RESET_PC;
        end else begin
            if (deq && head_valid) begin
                check_value("inst_o.pc", head.pc, exp_pc);
                check_value("inst_o.inst", head.inst, expected_word(exp_pc));
                exp_pc = exp_pc + 32'd4;
            end
            if (redirect.taken) begin
                exp_pc = redirect.target;
            end
            if (bmem_read) begin
                check_count++;
                assert (bmem_ready) else begin
                    error_count++;
                    $display("Memory read pulse at %0t ns while bmem_ready_i was low", $time);
                end
                check_value("bmem_addr_o offset", 32'(bmem_addr[`FE_OFFSET_W-1:0]), 32'd0);
            end
            if (drsp.valid) begin
                resp_count++;
                check_count++;
                assert (dreq.valid) else begin
                    error_count++;
                    $display("Data response strobe at %0t ns with no data request pending", $time);
                end
                for (w = 0; w < `FE_LINE_W / `FE_XLEN; w++) begin
                    check_value($sformatf("drsp_o.data[%0d]", w), drsp.data[32*w +: 32],
                                expected_word(dreq.addr + 32'(4 * w)));
                end
            end
        end
    end

    initial begin : main_sequence
        logic [31:0] r;
        logic        saw_full;
        int          n;
        rst      = 1'b1;
        deq      = 1'b0;
        redirect = '0;
        dreq     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        check_value("bmem_read_o", bmem_read, 32'd0);
        check_value("inst_valid_o", head_valid, 32'd0);
        check_value("drsp_o.valid", drsp.valid, 32'd0);
        check_value("irsp.valid", DUT.irsp.valid, 32'd0);
        check_value("push", DUT.push, 32'd0);
        check_value("ireq.valid", DUT.ireq.valid, 32'd0);
        #DRIVE_DELAY;
        rst = 1'b0;

        pop_entries(1);
        report_test("test 1 reset vector");

        pop_entries(SEQ_POPS);
        report_test("test 2 sequential fetch");

        for (n = 0; n < 2; n++) begin
            while (!head_valid) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            saw_full = 1'b0;
            repeat (STALL_CYCLES) begin
                @(posedge clk);
                saw_full = saw_full | DUT.queue_full;
                #DRIVE_DELAY;
            end
            check_count++;
            assert (saw_full) else begin
                error_count++;
                $display("Fetch queue never filled while popping was held off");
            end
            pop_entries(BP_POPS);
        end
        report_test("test 3 back-pressure");

        for (n = 0; n < N_REDIRECTS; n++) begin
            r = next_random();
            pop_entries(r % 6);
            r = next_random();
            redirect.taken  = 1'b1;
            redirect.target = {r[31:2], 2'b00};
            @(posedge clk);
            #DRIVE_DELAY;
            redirect = '0;
            pop_entries(REDIRECT_POPS);
        end
        report_test("test 4 redirect");

        fork
            pop_entries(DATA_POPS);
            issue_data_requests();
        join
        check_count++;
        assert (resp_count == req_count) else begin
            error_count++;
            $display("Data port gave %0d responses for %0d requests", resp_count, req_count);
        end
        report_test("test 5 data port");

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the fetch stream stalled", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule : tb_fetch_frontend

// ==== vlog.f ====
+incdir+design
design/frontend_pkg.sv
design/burst_adapter.sv
design/mem_arbiter.sv
design/fetch_ctrl.sv
design/fetch_queue.sv
design/fetch_frontend.sv
dv/bmem_model.sv
dv/tb_fetch_frontend.sv

// ==== Bender.yml ====
package:
  name: fetch_frontend

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/frontend_pkg.sv
      - design/burst_adapter.sv
      - design/mem_arbiter.sv
      - design/fetch_ctrl.sv
      - design/fetch_queue.sv
      - design/fetch_frontend.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/bmem_model.sv
      - dv/tb_fetch_frontend.sv
